/* common/trap_pkg.sv */
// shared trap constants and FSM state type, imported by the trap subsystem RTL and testbench
package trap_pkg;

    // register and address width
    parameter int XLEN = 32;

    // machine CSR addresses
    parameter logic [11:0] CSR_MSTATUS = 12'h300;
    parameter logic [11:0] CSR_MIE     = 12'h304;
    parameter logic [11:0] CSR_MTVEC   = 12'h305;
    parameter logic [11:0] CSR_MEPC    = 12'h341;
    parameter logic [11:0] CSR_MCAUSE  = 12'h342;

    // global interrupt enable in mstatus
    parameter int MSTATUS_MIE_BIT = 3;

    // synchronous exception causes
    parameter logic [XLEN-1:0] CAUSE_ECALL  = 32'd11;
    parameter logic [XLEN-1:0] CAUSE_EBREAK = 32'd3;

    // external line n maps to cause 16+n, also its mie bit
    parameter int IRQ_CAUSE_BASE = 16;

    // trap sequencer states
    typedef enum logic [2:0] {
        S_IDLE          = 3'd0,
        S_WRITE_MCAUSE  = 3'd1,
        S_WRITE_MEPC    = 3'd2,
        S_WRITE_MSTATUS = 3'd3,
        S_JUMP          = 3'd4
    } trap_state_t;

endpackage

/* interrupt/irq_gateway.sv */
// one external interrupt line: synchronizer, pending latch and clear on claim, one per line
module irq_gateway (
    input  logic clk,
    input  logic rst_n,
    input  logic irq_i,
    input  logic enable_i,
    input  logic claim_i,
    output logic pending_o
);

    logic [1:0] sync_q;
    logic       pending_q;

    // two-flop synchronizer for the async line
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q <= 2'b00;
        end else begin
            sync_q <= {sync_q[0], irq_i};
        end
    end

    // claim clears first; a still-high line sets it again next cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending_q <= 1'b0;
        end else if (claim_i) begin
            pending_q <= 1'b0;
        end else if (sync_q[1] && enable_i) begin
            pending_q <= 1'b1;
        end
    end

    // masked, latch kept while disabled
    assign pending_o = pending_q & enable_i;

endmodule

/* interrupt/irq_arbiter.sv */
// fixed-priority pick among pending lines, giving the interrupt cause, vector address and claim
module irq_arbiter
    import trap_pkg::*;
#(
    parameter int NUM_IRQ = 4
) (
    input  logic [NUM_IRQ-1:0] pending_i,
    input  logic [XLEN-1:0]    mtvec_i,
    input  logic               int_ack_i,
    output logic               int_req_o,
    output logic [XLEN-1:0]    int_cause_o,
    output logic [XLEN-1:0]    int_addr_o,
    output logic [NUM_IRQ-1:0] claim_o
);

    logic [4:0]         win_idx;
    logic [NUM_IRQ-1:0] win_onehot;
    logic [XLEN-2:0]    cause_num;

    // walk downward so the lowest pending index is left standing
    always_comb begin
        win_idx    = '0;
        win_onehot = '0;
        for (int i = NUM_IRQ - 1; i >= 0; i--) begin
            if (pending_i[i]) begin
                win_idx    = 5'(i);
                win_onehot = '0;
                win_onehot[i] = 1'b1;
            end
        end
    end

    assign int_req_o = |pending_i;

    assign cause_num   = (XLEN-1)'(IRQ_CAUSE_BASE) + (XLEN-1)'(win_idx);
    assign int_cause_o = {1'b1, cause_num};

    // vectored mode gives base plus 4*cause
    assign int_addr_o = {mtvec_i[XLEN-1:2], 2'b00} + {cause_num[XLEN-3:0], 2'b00};

    assign claim_o = int_ack_i ? win_onehot : '0;

endmodule

/* design/trap_csr.sv */
// machine CSR file with a trap write port (from the sequencer) and a software port (from the pipeline)
module trap_csr
    import trap_pkg::*;
#(
    parameter int NUM_IRQ = 4
) (
    input  logic               clk,
    input  logic               rst_n,

    // trap sequencer port
    input  logic               trap_we_i,
    input  logic [11:0]        trap_waddr_i,
    input  logic [XLEN-1:0]    trap_wdata_i,

    // software access port
    input  logic               sw_we_i,
    input  logic [11:0]        sw_addr_i,
    input  logic [XLEN-1:0]    sw_wdata_i,
    input  logic [11:0]        sw_raddr_i,
    output logic [XLEN-1:0]    sw_rdata_o,

    output logic [XLEN-1:0]    mstatus_o,
    output logic [XLEN-1:0]    mtvec_o,
    output logic [XLEN-1:0]    mepc_o,
    output logic [NUM_IRQ-1:0] mie_en_o
);

    logic [XLEN-1:0] mstatus_q;
    logic [XLEN-1:0] mie_q;
    logic [XLEN-1:0] mtvec_q;
    logic [XLEN-1:0] mepc_q;
    logic [XLEN-1:0] mcause_q;

    logic            wr_en;
    logic [11:0]     wr_addr;
    logic [XLEN-1:0] wr_data;

    // trap port wins, software write dropped on collision
    assign wr_en   = trap_we_i | sw_we_i;
    assign wr_addr = trap_we_i ? trap_waddr_i : sw_addr_i;
    assign wr_data = trap_we_i ? trap_wdata_i : sw_wdata_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mstatus_q <= '0;
            mie_q     <= '0;
            mtvec_q   <= '0;
            mepc_q    <= '0;
            mcause_q  <= '0;
        end else if (wr_en) begin
            case (wr_addr)
                CSR_MSTATUS: mstatus_q <= wr_data;
                CSR_MIE:     mie_q     <= wr_data;
                CSR_MTVEC:   mtvec_q   <= wr_data;
                CSR_MEPC:    mepc_q    <= wr_data;
                CSR_MCAUSE:  mcause_q  <= wr_data;
                default:     ;
            endcase
        end
    end

    // combinational read, unknown addresses give zero
    always_comb begin
        case (sw_raddr_i)
            CSR_MSTATUS: sw_rdata_o = mstatus_q;
            CSR_MIE:     sw_rdata_o = mie_q;
            CSR_MTVEC:   sw_rdata_o = mtvec_q;
            CSR_MEPC:    sw_rdata_o = mepc_q;
            CSR_MCAUSE:  sw_rdata_o = mcause_q;
            default:     sw_rdata_o = '0;
        endcase
    end

    assign mstatus_o = mstatus_q;
    assign mtvec_o   = mtvec_q;
    assign mepc_o    = mepc_q;

    // per-line enables live at mie[16 +: NUM_IRQ]
    assign mie_en_o  = mie_q[IRQ_CAUSE_BASE +: NUM_IRQ];

endmodule

/* exception/exception.sv */
// trap sequencer turning ecall, ebreak and interrupts into CSR writes and a jump, and handling mret
module exception
    import trap_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,

    // instruction side
    input  logic [XLEN-1:0] inst_addr_i,
    input  logic            inst_valid_i,
    input  logic            ecall_i,
    input  logic            ebreak_i,
    input  logic            mret_i,

    // CSR values
    input  logic [XLEN-1:0] mtvec_i,
    input  logic [XLEN-1:0] mepc_i,
    input  logic [XLEN-1:0] mstatus_i,

    // from the arbiter
    input  logic            int_req_i,
    input  logic [XLEN-1:0] int_cause_i,
    input  logic [XLEN-1:0] int_addr_i,
    output logic            int_ack_o,

    // CSR write port
    output logic            trap_we_o,
    output logic [11:0]     trap_waddr_o,
    output logic [XLEN-1:0] trap_wdata_o,

    // to the pipeline
    output logic            stall_o,
    output logic [XLEN-1:0] jump_addr_o,
    output logic            jump_flag_o
);

    trap_state_t state_q;
    trap_state_t state_d;

    logic            is_int_q;
    logic [XLEN-1:0] cause_q;
    logic [XLEN-1:0] epc_q;
    logic [XLEN-1:0] int_addr_q;

    logic            take_int;
    logic            take_ecall;
    logic            take_ebreak;
    logic            take_mret;
    logic            enter;
    logic [XLEN-1:0] entry_cause;

    // interrupt only if globally enabled
    assign take_int    = int_req_i && mstatus_i[MSTATUS_MIE_BIT];
    assign take_ecall  = inst_valid_i && ecall_i;
    assign take_ebreak = inst_valid_i && ebreak_i;
    assign take_mret   = inst_valid_i && mret_i;

    assign enter = (state_q == S_IDLE) && (take_int || take_ecall || take_ebreak);

    // priority interrupt > ecall > ebreak
    assign entry_cause = take_int   ? int_cause_i :
                         take_ecall ? CAUSE_ECALL : CAUSE_EBREAK;

    assign int_ack_o = (state_q == S_IDLE) && take_int;

    always_comb begin
        state_d      = state_q;
        trap_we_o    = 1'b0;
        trap_waddr_o = '0;
        trap_wdata_o = '0;
        stall_o      = 1'b0;
        jump_addr_o  = '0;
        jump_flag_o  = 1'b0;

        case (state_q)
            S_IDLE: begin
                if (enter) begin
                    stall_o = 1'b1;
                    state_d = S_WRITE_MCAUSE;
                end else if (take_mret) begin
                    // return now, re-enable interrupts
                    jump_flag_o  = 1'b1;
                    jump_addr_o  = mepc_i;
                    trap_we_o    = 1'b1;
                    trap_waddr_o = CSR_MSTATUS;
                    trap_wdata_o = mstatus_i;
                    trap_wdata_o[MSTATUS_MIE_BIT] = 1'b1;
                end
            end
            S_WRITE_MCAUSE: begin
                stall_o      = 1'b1;
                trap_we_o    = 1'b1;
                trap_waddr_o = CSR_MCAUSE;
                trap_wdata_o = cause_q;
                state_d      = S_WRITE_MEPC;
            end
            S_WRITE_MEPC: begin
                stall_o      = 1'b1;
                trap_we_o    = 1'b1;
                trap_waddr_o = CSR_MEPC;
                trap_wdata_o = epc_q;
                state_d      = S_WRITE_MSTATUS;
            end
            S_WRITE_MSTATUS: begin
                stall_o      = 1'b1;
                trap_we_o    = 1'b1;
                trap_waddr_o = CSR_MSTATUS;
                trap_wdata_o = mstatus_i;
                trap_wdata_o[MSTATUS_MIE_BIT] = 1'b0;
                state_d      = S_JUMP;
            end
            S_JUMP: begin
                jump_flag_o = 1'b1;
                jump_addr_o = is_int_q ? int_addr_q : mtvec_i;
                state_d     = S_IDLE;
            end
            default: state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= S_IDLE;
            is_int_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (enter) begin
                is_int_q <= take_int;
            end
        end
    end

    // trap payload captured on entry
    always_ff @(posedge clk) begin
        if (enter) begin
            cause_q    <= entry_cause;
            epc_q      <= inst_addr_i;
            int_addr_q <= int_addr_i;
        end
    end

endmodule

/* design/trap_unit_top.sv */
// trap subsystem top: CSR file, interrupt gateways, arbiter and sequencer, driven by the pipeline
module trap_unit_top
    import trap_pkg::*;
#(
    parameter int NUM_IRQ = 4
) (
    input  logic               clk,
    input  logic               rst_n,

    input  logic [XLEN-1:0]    inst_addr_i,
    input  logic               inst_valid_i,
    input  logic               ecall_i,
    input  logic               ebreak_i,
    input  logic               mret_i,

    input  logic [NUM_IRQ-1:0] irq_i,

    input  logic               sw_we_i,
    input  logic [11:0]        sw_addr_i,
    input  logic [XLEN-1:0]    sw_wdata_i,
    input  logic [11:0]        sw_raddr_i,
    output logic [XLEN-1:0]    sw_rdata_o,

    output logic               stall_o,
    output logic               jump_flag_o,
    output logic [XLEN-1:0]    jump_addr_o
);

    logic [NUM_IRQ-1:0] mie_en;
    logic [NUM_IRQ-1:0] pending;
    logic [NUM_IRQ-1:0] claim;

    logic [XLEN-1:0]    mstatus;
    logic [XLEN-1:0]    mtvec;
    logic [XLEN-1:0]    mepc;

    logic               int_req;
    logic               int_ack;
    logic [XLEN-1:0]    int_cause;
    logic [XLEN-1:0]    int_addr;

    logic               trap_we;
    logic [11:0]        trap_waddr;
    logic [XLEN-1:0]    trap_wdata;

    trap_csr #(
        .NUM_IRQ(NUM_IRQ)
    ) trap_csr_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .trap_we_i    (trap_we),
        .trap_waddr_i (trap_waddr),
        .trap_wdata_i (trap_wdata),
        .sw_we_i      (sw_we_i),
        .sw_addr_i    (sw_addr_i),
        .sw_wdata_i   (sw_wdata_i),
        .sw_raddr_i   (sw_raddr_i),
        .sw_rdata_o   (sw_rdata_o),
        .mstatus_o    (mstatus),
        .mtvec_o      (mtvec),
        .mepc_o       (mepc),
        .mie_en_o     (mie_en)
    );

    // one gateway per external line
    for (genvar n = 0; n < NUM_IRQ; n++) begin : g_gateway
        irq_gateway irq_gateway_i (
            .clk       (clk),
            .rst_n     (rst_n),
            .irq_i     (irq_i[n]),
            .enable_i  (mie_en[n]),
            .claim_i   (claim[n]),
            .pending_o (pending[n])
        );
    end

    irq_arbiter #(
        .NUM_IRQ(NUM_IRQ)
    ) irq_arbiter_i (
        .pending_i   (pending),
        .mtvec_i     (mtvec),
        .int_ack_i   (int_ack),
        .int_req_o   (int_req),
        .int_cause_o (int_cause),
        .int_addr_o  (int_addr),
        .claim_o     (claim)
    );

    exception exception_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .inst_addr_i  (inst_addr_i),
        .inst_valid_i (inst_valid_i),
        .ecall_i      (ecall_i),
        .ebreak_i     (ebreak_i),
        .mret_i       (mret_i),
        .mtvec_i      (mtvec),
        .mepc_i       (mepc),
        .mstatus_i    (mstatus),
        .int_req_i    (int_req),
        .int_cause_i  (int_cause),
        .int_addr_i   (int_addr),
        .int_ack_o    (int_ack),
        .trap_we_o    (trap_we),
        .trap_waddr_o (trap_waddr),
        .trap_wdata_o (trap_wdata),
        .stall_o      (stall_o),
        .jump_addr_o  (jump_addr_o),
        .jump_flag_o  (jump_flag_o)
    );

endmodule

/* verification/trap_unit_tb.sv */
// testbench for trap_unit_top, plays the pipeline and interrupt sources and checks each trap
module trap_unit_tb
    import trap_pkg::*;
();

    localparam int NUM_IRQ = 4;
    // rough cycle count of reset plus all tests
    localparam int RUN_CYCLES = 8 + 4 + 14 + 3 + 32 + 32 + 26;

    logic               clk;
    logic               rst_n;
    logic [XLEN-1:0]    inst_addr;
    logic               inst_valid;
    logic               ecall;
    logic               ebreak;
    logic               mret;
    logic [NUM_IRQ-1:0] irq;
    logic               sw_we;
    logic [11:0]        sw_addr;
    logic [XLEN-1:0]    sw_wdata;
    logic [11:0]        sw_raddr;
    logic [XLEN-1:0]    sw_rdata;
    logic               stall;
    logic               jump_flag;
    logic [XLEN-1:0]    jump_addr;

    int                 error_count;
    int                 test_count;
    int                 failed_tests;
    logic [XLEN-1:0]    mtvec_val;
    logic [XLEN-1:0]    epc_model;
    trap_state_t        fsm_state;

    trap_unit_top #(
        .NUM_IRQ(NUM_IRQ)
    ) trap_unit_top_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .inst_addr_i  (inst_addr),
        .inst_valid_i (inst_valid),
        .ecall_i      (ecall),
        .ebreak_i     (ebreak),
        .mret_i       (mret),
        .irq_i        (irq),
        .sw_we_i      (sw_we),
        .sw_addr_i    (sw_addr),
        .sw_wdata_i   (sw_wdata),
        .sw_raddr_i   (sw_raddr),
        .sw_rdata_o   (sw_rdata),
        .stall_o      (stall),
        .jump_flag_o  (jump_flag),
        .jump_addr_o  (jump_addr)
    );

    assign fsm_state = trap_unit_top_i.exception_i.state_q;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        repeat (RUN_CYCLES * 2) @(posedge clk);
        $display("watchdog expired, the tests did not finish in time");
        $display("Simulation failed");
        $finish;
    end

    assert property (@(posedge clk) disable iff (!rst_n) !(stall && jump_flag))
        else begin
            error_count++;
            $display("stall and jump pulse high together in state %s", fsm_state.name());
        end

    // entry is the cycle where stall rises
    assert property (@(posedge clk) disable iff (!rst_n)
        ($past(stall, 4) && !$past(stall, 5)) |-> jump_flag)
        else begin
            error_count++;
            $display("no jump pulse four cycles after trap entry, state %s", fsm_state.name());
        end

    assert property (@(posedge clk) !rst_n |-> (!stall && !jump_flag))
        else begin
            error_count++;
            $display("stall or jump pulse seen during reset");
        end

    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    task automatic csr_write(input logic [11:0] addr, input logic [XLEN-1:0] data);
        sw_we    = 1'b1;
        sw_addr  = addr;
        sw_wdata = data;
        next_cycle();
        sw_we    = 1'b0;
    endtask

    task automatic csr_read(input logic [11:0] addr, output logic [XLEN-1:0] data);
        sw_raddr = addr;
        #1;
        data = sw_rdata;
    endtask

    task automatic check_value(input string name, input logic [XLEN-1:0] expected,
                               input logic [XLEN-1:0] actual);
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_csr(input string name, input logic [11:0] addr,
                             input logic [XLEN-1:0] expected);
        logic [XLEN-1:0] data;
        csr_read(addr, data);
        check_value(name, expected, data);
    endtask

    function automatic logic [XLEN-1:0] vector_addr(input int line);
        return {mtvec_val[XLEN-1:2], 2'b00} + XLEN'(4 * (IRQ_CAUSE_BASE + line));
    endfunction

    function automatic logic [XLEN-1:0] irq_cause(input int line);
        return 32'h8000_0000 | XLEN'(IRQ_CAUSE_BASE + line);
    endfunction

    // strobes drop after the first cycle; stall cycles are counted up to the jump
    task automatic trap_and_check(input string name, input logic [XLEN-1:0] exp_addr,
                                  input int exp_stalls);
        int stalls;
        int cycles;
        bit seen;
        stalls = 0;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < 10) begin
            @(negedge clk);
            if (jump_flag) begin
                seen = 1'b1;
                check_value(name, exp_addr, jump_addr);
            end else if (stall) begin
                stalls++;
            end
            next_cycle();
            inst_valid = 1'b0;
            ecall      = 1'b0;
            ebreak     = 1'b0;
            mret       = 1'b0;
            cycles++;
        end
        if (!seen) begin
            error_count++;
            $display("%s: no jump pulse within 10 cycles", name);
        end else if (stalls != exp_stalls) begin
            error_count++;
            $display("[ERROR] %s stall cycles: expected %0d, actual %0d",
                     name, exp_stalls, stalls);
        end
    endtask

    task automatic expect_quiet(input string name, input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            if (stall || jump_flag) begin
                error_count++;
                $display("%s: unexpected stall or jump while no trap is due", name);
            end
            next_cycle();
        end
    endtask

    task automatic return_from_trap(input string name);
        inst_valid = 1'b1;
        mret       = 1'b1;
        trap_and_check(name, epc_model, 0);
    endtask

    // latch pending lines with MIE off, then drop the lines again
    task automatic arm_lines(input logic [NUM_IRQ-1:0] mask);
        csr_write(CSR_MSTATUS, 32'h0);
        csr_write(CSR_MIE, XLEN'(mask) << IRQ_CAUSE_BASE);
        irq = mask;
        repeat (4) next_cycle();
        irq = '0;
        repeat (3) next_cycle();
    endtask

    task automatic report_test(input string name, input int errors_before);
        test_count++;
        if (error_count != errors_before) begin
            failed_tests++;
        end
        $display("test %-14s %s", name, (error_count == errors_before) ? "ok" : "FAILED");
    endtask

    task automatic reset_values();
        int mark;
        mark = error_count;
        check_csr("reset", CSR_MSTATUS, '0);
        check_csr("reset", CSR_MIE, '0);
        check_csr("reset", CSR_MTVEC, '0);
        check_csr("reset", CSR_MEPC, '0);
        check_csr("reset", CSR_MCAUSE, '0);
        expect_quiet("reset", 2);
        report_test("reset", mark);
    endtask

    task automatic exception_trap(input bit use_ebreak);
        int    mark;
        string name;
        mark      = error_count;
        name      = use_ebreak ? "ebreak" : "ecall";
        epc_model = $urandom & 32'hffff_fffc;
        csr_write(CSR_MSTATUS, 32'h8);
        inst_addr  = epc_model;
        inst_valid = 1'b1;
        ecall      = !use_ebreak;
        ebreak     = use_ebreak;
        trap_and_check(name, mtvec_val, 4);
        check_csr(name, CSR_MCAUSE, use_ebreak ? CAUSE_EBREAK : CAUSE_ECALL);
        check_csr(name, CSR_MEPC, epc_model);
        check_csr(name, CSR_MSTATUS, 32'h0);
        report_test(name, mark);
    endtask

    task automatic mret_return();
        int mark;
        mark = error_count;
        return_from_trap("mret");
        check_csr("mret", CSR_MSTATUS, 32'h8);
        report_test("mret", mark);
    endtask

    task automatic masked_irq();
        int mark;
        int line;
        mark = error_count;
        line = $urandom_range(NUM_IRQ - 1, 0);
        // MIE set, line disabled
        csr_write(CSR_MSTATUS, 32'h8);
        irq[line] = 1'b1;
        expect_quiet("irq single", 6);
        // line enabled, MIE clear
        csr_write(CSR_MSTATUS, 32'h0);
        csr_write(CSR_MIE, XLEN'(1) << (IRQ_CAUSE_BASE + line));
        expect_quiet("irq single", 6);
        irq[line] = 1'b0;
        epc_model = $urandom & 32'hffff_fffc;
        inst_addr = epc_model;
        csr_write(CSR_MSTATUS, 32'h8);
        trap_and_check("irq single", vector_addr(line), 4);
        check_csr("irq single", CSR_MCAUSE, irq_cause(line));
        return_from_trap("irq single");
        expect_quiet("irq single", 8);
        report_test("irq single", mark);
    endtask

    task automatic irq_priority();
        int mark;
        int low;
        int high;
        mark = error_count;
        low  = $urandom_range(NUM_IRQ - 2, 0);
        high = $urandom_range(NUM_IRQ - 1, low + 1);
        arm_lines((NUM_IRQ'(1) << low) | (NUM_IRQ'(1) << high));
        epc_model = $urandom & 32'hffff_fffc;
        inst_addr = epc_model;
        csr_write(CSR_MSTATUS, 32'h8);
        trap_and_check("irq priority", vector_addr(low), 4);
        check_csr("irq priority", CSR_MCAUSE, irq_cause(low));
        return_from_trap("irq priority");
        // second line is taken right after the return
        trap_and_check("irq priority", vector_addr(high), 4);
        check_csr("irq priority", CSR_MCAUSE, irq_cause(high));
        return_from_trap("irq priority");
        expect_quiet("irq priority", 8);
        report_test("irq priority", mark);
    endtask

    task automatic irq_beats_ecall();
        int mark;
        int line;
        mark = error_count;
        line = $urandom_range(NUM_IRQ - 1, 0);
        arm_lines(NUM_IRQ'(1) << line);
        epc_model = $urandom & 32'hffff_fffc;
        csr_write(CSR_MSTATUS, 32'h8);
        inst_addr  = epc_model;
        inst_valid = 1'b1;
        ecall      = 1'b1;
        next_cycle();
        inst_valid = 1'b0;
        ecall      = 1'b0;
        // lands on the mcause write
        csr_write(CSR_MTVEC, ~mtvec_val);
        trap_and_check("irq vs ecall", vector_addr(line), 2);
        check_csr("irq vs ecall", CSR_MCAUSE, irq_cause(line));
        check_csr("irq vs ecall", CSR_MEPC, epc_model);
        check_csr("irq vs ecall", CSR_MTVEC, mtvec_val);
        return_from_trap("irq vs ecall");
        expect_quiet("irq vs ecall", 8);
        report_test("irq vs ecall", mark);
    endtask

    initial begin
        void'($urandom(32'hde12));
        error_count  = 0;
        test_count   = 0;
        failed_tests = 0;
        epc_model    = '0;
        rst_n        = 1'b0;
        inst_addr    = '0;
        inst_valid   = 1'b0;
        ecall        = 1'b0;
        ebreak       = 1'b0;
        mret         = 1'b0;
        irq          = '0;
        sw_we        = 1'b0;
        sw_addr      = '0;
        sw_wdata     = '0;
        sw_raddr     = '0;
        repeat (8) @(posedge clk);
        #10;
        rst_n = 1'b1;

        reset_values();
        mtvec_val = $urandom;
        csr_write(CSR_MTVEC, mtvec_val);
        exception_trap(1'b0);
        exception_trap(1'b1);
        mret_return();
        masked_irq();
        irq_priority();
        irq_beats_ecall();

        $display("tests: %0d, failed: %0d, errors: %0d", test_count, failed_tests, error_count);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* build.f */
common/trap_pkg.sv
interrupt/irq_gateway.sv
interrupt/irq_arbiter.sv
design/trap_csr.sv
exception/exception.sv
design/trap_unit_top.sv
verification/trap_unit_tb.sv

/* run.sh */
#!/bin/sh
rm -f sim.log
verilator --binary --assert -Wno-fatal -f build.f --top-module trap_unit_tb -o trap_unit_sim \
    && ./obj_dir/trap_unit_sim > sim.log 2>&1
grep -q "Simulation passed" sim.log && echo "PASS" || { cat sim.log 2>/dev/null; echo "FAIL"; exit 1; }
